//--- segre_pkg.sv
package segre_pkg;

    // Width of data and address words
    localparam int WORD_SIZE = 32;

    // Number of store buffer entries, kept a power of two
    localparam int NUM_SB_ENTRIES = 4;

    // Read and write pointer width
    localparam int SB_ENTRY_BITS = $clog2(NUM_SB_ENTRIES);

    // Store buffer FSM states
    // NOT_FLUSHING accepts stores and drains on ALU cycles
    // FLUSHING drains one entry per cycle until empty
    typedef enum logic {
        NOT_FLUSHING = 1'b0,
        FLUSHING     = 1'b1
    } sb_state_t;

endpackage : segre_pkg

//--- segre_sb_entry_if.sv
`timescale 1ns/1ps

// Link between the controller, one buffer entry and the read mux
interface segre_sb_entry_if;

    // Write strobe, loads the pair and sets valid
    logic                            wr_en;
    // Clear strobe, frees the entry
    logic                            clr_en;
    // Pair to be written
    logic [segre_pkg::WORD_SIZE-1:0] wr_data;
    logic [segre_pkg::WORD_SIZE-1:0] wr_addr;

    // Entry state
    logic                            valid;
    logic [segre_pkg::WORD_SIZE-1:0] data;
    logic [segre_pkg::WORD_SIZE-1:0] addr;
    // Valid and address equals the lookup address
    logic                            match;

    // Controller side, drives strobes and sees occupancy
    modport ctrl (
        output wr_en,
        output clr_en,
        output wr_data,
        output wr_addr,
        input  valid,
        input  match
    );

    // Entry side, holds the stored pair
    modport ent (
        input  wr_en,
        input  clr_en,
        input  wr_data,
        input  wr_addr,
        output valid,
        output data,
        output addr,
        output match
    );

    // Read mux side
    modport rd (
        input valid,
        input data,
        input addr,
        input match
    );

endinterface : segre_sb_entry_if

//--- segre_sb_entry.sv
`timescale 1ns/1ps

// One store buffer slot with its own address comparator
module segre_sb_entry (
    input logic                            clk_i,
    input logic                            rsn_i,
    // Address looked up by loads and coalescing stores
    input logic [segre_pkg::WORD_SIZE-1:0] lookup_addr_i,
    segre_sb_entry_if.ent                  ent
);

    logic                            valid_q;
    logic [segre_pkg::WORD_SIZE-1:0] data_q;
    logic [segre_pkg::WORD_SIZE-1:0] addr_q;

    // Valid bit
    // A write has priority over a clear in the same cycle
    always_ff @(posedge clk_i or negedge rsn_i) begin
        if (!rsn_i) begin
            valid_q <= 1'b0;
        end else if (ent.wr_en) begin
            valid_q <= 1'b1;
        end else if (ent.clr_en) begin
            valid_q <= 1'b0;
        end
    end

    // Stored pair, only meaningful while valid
    always_ff @(posedge clk_i) begin
        if (ent.wr_en) begin
            data_q <= ent.wr_data;
            addr_q <= ent.wr_addr;
        end
    end

    assign ent.valid = valid_q;
    assign ent.data  = data_q;
    assign ent.addr  = addr_q;

    // Address match, used for forwarding and coalescing
    assign ent.match = valid_q && (addr_q == lookup_addr_i);

    // Free slots are only ever allocated
    // The controller must not drain an entry that holds nothing
    a_no_clear_on_free: assert property (
        @(posedge clk_i) disable iff (!rsn_i)
        !(ent.wr_en && ent.clr_en && !valid_q)
    ) else $error("sb_entry: write and clear on a free entry");

endmodule : segre_sb_entry

//--- segre_sb_ctrl.sv
`timescale 1ns/1ps

// Write and drain control of the store buffer
module segre_sb_ctrl (
    input  logic                                clk_i,
    input  logic                                rsn_i,
    // Store payload and lookup address
    input  logic [segre_pkg::WORD_SIZE-1:0]     data_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     addr_i,
    // Instruction class, at most one set
    input  logic                                is_load_i,
    input  logic                                is_store_i,
    input  logic                                is_alu_i,
    // Cache found the line for the store
    input  logic                                is_hit_i,
    segre_sb_entry_if.ctrl                      ents [segre_pkg::NUM_SB_ENTRIES-1:0],
    // Head of the circular buffer
    output logic [segre_pkg::SB_ENTRY_BITS-1:0] rd_ptr_o,
    // Head entry leaves toward the cache this cycle
    output logic                                drain_o
);

    segre_pkg::sb_state_t state_q;
    segre_pkg::sb_state_t state_d;

    logic [segre_pkg::SB_ENTRY_BITS-1:0]  rd_ptr_q;
    logic [segre_pkg::SB_ENTRY_BITS-1:0]  wr_ptr_q;

    logic [segre_pkg::NUM_SB_ENTRIES-1:0] valid_vec;
    logic [segre_pkg::NUM_SB_ENTRIES-1:0] match_vec;
    logic [segre_pkg::NUM_SB_ENTRIES-1:0] wr_dec;
    logic [segre_pkg::NUM_SB_ENTRIES-1:0] rd_dec;
    logic [segre_pkg::NUM_SB_ENTRIES-1:0] wr_en_vec;
    logic [segre_pkg::NUM_SB_ENTRIES-1:0] clr_en_vec;

    logic full;
    logic empty;
    logic any_match;
    logic store_ok;
    logic coalesce;
    logic alloc;
    logic drain;

    // Gather occupancy and match bits, fan out strobes and payload
    for (genvar i = 0; i < segre_pkg::NUM_SB_ENTRIES; i++) begin : g_ents
        assign valid_vec[i]     = ents[i].valid;
        assign match_vec[i]     = ents[i].match;
        assign ents[i].wr_en    = wr_en_vec[i];
        assign ents[i].clr_en   = clr_en_vec[i];
        assign ents[i].wr_data  = data_i;
        assign ents[i].wr_addr  = addr_i;
    end

    // Occupancy comes straight from the valid bits
    assign full      = &valid_vec;
    assign empty     = ~|valid_vec;
    assign any_match = |match_vec;

    // Stores are accepted only outside a flush and on a cache hit
    assign store_ok = (state_q == segre_pkg::NOT_FLUSHING) && is_store_i && is_hit_i;
    // Same address already buffered, overwrite in place even if full
    assign coalesce = store_ok && any_match;
    // New address, needs a free slot at the write pointer
    assign alloc    = store_ok && !any_match && !full;

    // Drain on ALU cycles, or every cycle while flushing
    assign drain = !empty &&
                   ((state_q == segre_pkg::FLUSHING) ||
                    (is_alu_i && (state_q == segre_pkg::NOT_FLUSHING)));

    // Pointer decode
    assign wr_dec = {{(segre_pkg::NUM_SB_ENTRIES-1){1'b0}}, 1'b1} << wr_ptr_q;
    assign rd_dec = {{(segre_pkg::NUM_SB_ENTRIES-1){1'b0}}, 1'b1} << rd_ptr_q;

    // Coalescing write goes to the matching slot, otherwise to the tail
    assign wr_en_vec  = coalesce ? match_vec :
                        alloc    ? wr_dec    : '0;
    assign clr_en_vec = drain ? rd_dec : '0;

    // Pointers wrap naturally, entry count is a power of two
    always_ff @(posedge clk_i or negedge rsn_i) begin
        if (!rsn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (alloc) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (drain) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Flush FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            segre_pkg::NOT_FLUSHING: begin
                // Store with no room, or load that misses the buffer
                if ((is_store_i && full && !any_match) || (is_load_i && !any_match)) begin
                    state_d = segre_pkg::FLUSHING;
                end
            end
            segre_pkg::FLUSHING: begin
                // Leave once a cycle starts with nothing left
                if (empty) begin
                    state_d = segre_pkg::NOT_FLUSHING;
                end
            end
            default: state_d = segre_pkg::NOT_FLUSHING;
        endcase
    end

    always_ff @(posedge clk_i or negedge rsn_i) begin
        if (!rsn_i) begin
            state_q <= segre_pkg::NOT_FLUSHING;
        end else begin
            state_q <= state_d;
        end
    end

    assign rd_ptr_o = rd_ptr_q;
    assign drain_o  = drain;

    // Decode stage delivers one instruction class per cycle
    a_strobes_onehot: assert property (
        @(posedge clk_i) disable iff (!rsn_i)
        $onehot0({is_load_i, is_store_i, is_alu_i})
    ) else $error("sb_ctrl: more than one instruction strobe");

    // A flush only ends with every entry drained
    // No store may slip in on the exit edge
    a_flush_until_empty: assert property (
        @(posedge clk_i) disable iff (!rsn_i)
        $fell(state_q == segre_pkg::FLUSHING) |-> empty
    ) else $error("sb_ctrl: flush left with entries pending");

endmodule : segre_sb_ctrl

//--- segre_sb_read.sv
`timescale 1ns/1ps

// Output mux of the store buffer
module segre_sb_read (
    // Load lookup active
    input  logic                                load_i,
    // Head entry index
    input  logic [segre_pkg::SB_ENTRY_BITS-1:0] rd_ptr_i,
    // Head entry is being drained
    input  logic                                drain_i,
    segre_sb_entry_if.rd                        ents [segre_pkg::NUM_SB_ENTRIES-1:0],
    output logic [segre_pkg::WORD_SIZE-1:0]     data_o,
    output logic [segre_pkg::WORD_SIZE-1:0]     addr_o,
    output logic                                is_hit_o
);

    logic [segre_pkg::NUM_SB_ENTRIES-1:0] valid_vec;
    logic [segre_pkg::NUM_SB_ENTRIES-1:0] match_vec;
    logic [segre_pkg::WORD_SIZE-1:0]      ent_data [segre_pkg::NUM_SB_ENTRIES];
    logic [segre_pkg::WORD_SIZE-1:0]      ent_addr [segre_pkg::NUM_SB_ENTRIES];
    logic [segre_pkg::WORD_SIZE-1:0]      fwd_data;
    logic [segre_pkg::WORD_SIZE-1:0]      fwd_addr;
    logic                                 is_hit;

    // Flatten the interface array so it can be indexed by the pointer
    for (genvar i = 0; i < segre_pkg::NUM_SB_ENTRIES; i++) begin : g_ents
        assign valid_vec[i] = ents[i].valid;
        assign match_vec[i] = ents[i].match;
        assign ent_data[i]  = ents[i].data;
        assign ent_addr[i]  = ents[i].addr;
    end

    // One-hot forwarding mux
    // Coalescing keeps at most one match, so no age ranking is needed
    always_comb begin
        fwd_data = '0;
        fwd_addr = '0;
        for (int i = 0; i < segre_pkg::NUM_SB_ENTRIES; i++) begin
            if (match_vec[i]) begin
                fwd_data = fwd_data | ent_data[i];
                fwd_addr = fwd_addr | ent_addr[i];
            end
        end
    end

    assign is_hit = load_i && |match_vec;

    // Forwarded load wins over the drained head, idle output is zero
    always_comb begin
        if (is_hit) begin
            data_o = fwd_data;
            addr_o = fwd_addr;
        end else if (drain_i) begin
            data_o = ent_data[rd_ptr_i];
            addr_o = ent_addr[rd_ptr_i];
        end else begin
            data_o = '0;
            addr_o = '0;
        end
    end

    assign is_hit_o = is_hit;

    // Coalescing invariant and head occupancy, checked after settling
    always_comb begin
        a_single_match: assert final ($onehot0(match_vec))
            else $error("sb_read: several entries match one address");
        a_head_valid: assert final (!drain_i || valid_vec[rd_ptr_i])
            else $error("sb_read: drain of a free head entry");
    end

endmodule : segre_sb_read

//--- segre_store_buffer.sv
`timescale 1ns/1ps

// Store buffer of the memory stage
// Holds cache-hitting stores, forwards to loads, drains toward the cache
module segre_store_buffer (
    input  logic                            clk_i,
    input  logic                            rsn_i,
    // Store payload and lookup address
    input  logic [segre_pkg::WORD_SIZE-1:0] data_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] addr_i,
    // Instruction class, at most one set
    input  logic                            is_load_i,
    input  logic                            is_store_i,
    input  logic                            is_alu_i,
    // Cache found the line for the store, store ignored otherwise
    input  logic                            is_hit_i,
    // Forwarded entry on a hit, head entry on a drain
    output logic [segre_pkg::WORD_SIZE-1:0] data_o,
    output logic [segre_pkg::WORD_SIZE-1:0] addr_o,
    // Load served from the buffer
    output logic                            is_hit_o,
    // Head entry goes to the cache this cycle
    output logic                            reading_valid_entry_o
);

    logic [segre_pkg::SB_ENTRY_BITS-1:0] rd_ptr;
    logic                                drain;

    // One link per entry
    segre_sb_entry_if sb_if [segre_pkg::NUM_SB_ENTRIES-1:0] ();

    // Pointers, flush FSM and strobes
    segre_sb_ctrl i_ctrl (
        .clk_i      (clk_i),
        .rsn_i      (rsn_i),
        .data_i     (data_i),
        .addr_i     (addr_i),
        .is_load_i  (is_load_i),
        .is_store_i (is_store_i),
        .is_alu_i   (is_alu_i),
        .is_hit_i   (is_hit_i),
        .ents       (sb_if),
        .rd_ptr_o   (rd_ptr),
        .drain_o    (drain)
    );

    // Entry storage, all compared against the same lookup address
    for (genvar i = 0; i < segre_pkg::NUM_SB_ENTRIES; i++) begin : g_entry
        segre_sb_entry i_entry (
            .clk_i         (clk_i),
            .rsn_i         (rsn_i),
            .lookup_addr_i (addr_i),
            .ent           (sb_if[i])
        );
    end

    // Output selection
    segre_sb_read i_read (
        .load_i   (is_load_i),
        .rd_ptr_i (rd_ptr),
        .drain_i  (drain),
        .ents     (sb_if),
        .data_o   (data_o),
        .addr_o   (addr_o),
        .is_hit_o (is_hit_o)
    );

    assign reading_valid_entry_o = drain;

endmodule : segre_store_buffer

//--- tb_segre_store_buffer.sv
`timescale 1ns/1ps

module tb_segre_store_buffer;

    logic                            clk_i;
    logic                            rsn_i;
    logic [segre_pkg::WORD_SIZE-1:0] data_i;
    logic [segre_pkg::WORD_SIZE-1:0] addr_i;
    logic                            is_load_i;
    logic                            is_store_i;
    logic                            is_alu_i;
    logic                            is_hit_i;
    logic [segre_pkg::WORD_SIZE-1:0] data_o;
    logic [segre_pkg::WORD_SIZE-1:0] addr_o;
    logic                            is_hit_o;
    logic                            reading_valid_entry_o;

    // Reference model, oldest entry at the front
    logic [segre_pkg::WORD_SIZE-1:0] m_addr[$];
    logic [segre_pkg::WORD_SIZE-1:0] m_data[$];
    segre_pkg::sb_state_t            m_state;

    integer seed = 32'h895b6b13;
    int     errors = 0;
    int     checks = 0;
    int     tests_ok = 0;
    int     tests_bad = 0;
    int     cycle_cnt = 0;
    logic   seen_drain;
    int     drains;
    int     err_mark;

    // Reset, then directed tests, then the random mix, plus margin
    int cycle_limit = 10 + 3 + 15 + 12 + 8 + 30 + 2000 + 100;

    segre_store_buffer i_dut (
        .clk_i                 (clk_i),
        .rsn_i                 (rsn_i),
        .data_i                (data_i),
        .addr_i                (addr_i),
        .is_load_i             (is_load_i),
        .is_store_i            (is_store_i),
        .is_alu_i              (is_alu_i),
        .is_hit_i              (is_hit_i),
        .data_o                (data_o),
        .addr_o                (addr_o),
        .is_hit_o              (is_hit_o),
        .reading_valid_entry_o (reading_valid_entry_o)
    );

    // 20 ns clock
    always #10 clk_i = ~clk_i;

    // Watchdog
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Run stopped, no end after %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    // Address pool, small so that hits and coalescing are frequent
    function automatic logic [segre_pkg::WORD_SIZE-1:0] pool_addr(input int idx);
        return 32'h8000_0100 + (idx << 2);
    endfunction

    // Position of an address in the model, -1 if absent
    function automatic int model_find(input logic [segre_pkg::WORD_SIZE-1:0] a);
        for (int i = 0; i < m_addr.size(); i++) begin
            if (m_addr[i] == a) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %0t %s expected %0b got %0b", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // One clock cycle: drive, check mid-cycle, step the model
    task automatic run_cycle(input logic ld, input logic st, input logic alu,
                             input logic hit, input logic [31:0] a, input logic [31:0] d);
        int          idx;
        logic        full;
        logic        empty;
        logic        exp_hit;
        logic        exp_drain;
        logic        store_ok;
        logic [31:0] exp_data;
        logic [31:0] exp_addr;
        @(posedge clk_i);
        #2;
        is_load_i  = ld;
        is_store_i = st;
        is_alu_i   = alu;
        is_hit_i   = hit;
        addr_i     = a;
        data_i     = d;
        #10;
        idx       = model_find(a);
        full      = (m_addr.size() == segre_pkg::NUM_SB_ENTRIES);
        empty     = (m_addr.size() == 0);
        exp_hit   = ld && (idx >= 0);
        exp_drain = !empty && ((m_state == segre_pkg::FLUSHING) || alu);
        // Forwarding beats the drained head
        if (exp_hit) begin
            exp_data = m_data[idx];
            exp_addr = m_addr[idx];
        end else if (exp_drain) begin
            exp_data = m_data[0];
            exp_addr = m_addr[0];
        end else begin
            exp_data = '0;
            exp_addr = '0;
        end
        check_bit("is_hit_o", exp_hit, is_hit_o);
        check_bit("reading_valid_entry_o", exp_drain, reading_valid_entry_o);
        check_word("data_o", exp_data, data_o);
        check_word("addr_o", exp_addr, addr_o);
        seen_drain = reading_valid_entry_o;
        store_ok = (m_state == segre_pkg::NOT_FLUSHING) && st && hit;
        // Flush entry and exit
        if (m_state == segre_pkg::NOT_FLUSHING) begin
            if ((st && full && idx < 0) || (ld && idx < 0)) begin
                m_state = segre_pkg::FLUSHING;
            end
        end else if (empty) begin
            m_state = segre_pkg::NOT_FLUSHING;
        end
        // Coalesce in place, else allocate if room
        if (store_ok && idx >= 0) begin
            m_data[idx] = d;
        end else if (store_ok && !full) begin
            m_addr.push_back(a);
            m_data.push_back(d);
        end
        if (exp_drain) begin
            void'(m_addr.pop_front());
            void'(m_data.pop_front());
        end
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic store_word(input logic [31:0] a, input logic [31:0] d);
        run_cycle(1'b0, 1'b1, 1'b0, 1'b1, a, d);
    endtask

    task automatic load_word(input logic [31:0] a);
        run_cycle(1'b1, 1'b0, 1'b0, 1'b0, a, '0);
    endtask

    task automatic alu_cycle();
        run_cycle(1'b0, 1'b0, 1'b1, 1'b0, '0, '0);
    endtask

    // Idle until the model leaves FLUSHING
    task automatic wait_flush_done();
        int n;
        n = 0;
        while (m_state == segre_pkg::FLUSHING && n < segre_pkg::NUM_SB_ENTRIES + 2) begin
            idle_cycle();
            n++;
        end
        if (m_state == segre_pkg::FLUSHING) begin
            errors++;
            $display("Flush still running after %0d idle cycles at %0t", n, $time);
        end
    endtask

    task automatic close_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_ok++;
            $display("%-14s done, no errors", name);
        end else begin
            tests_bad++;
            $display("%-14s done, %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        clk_i      = 1'b0;
        rsn_i      = 1'b0;
        data_i     = '0;
        addr_i     = '0;
        is_load_i  = 1'b0;
        is_store_i = 1'b0;
        is_alu_i   = 1'b0;
        is_hit_i   = 1'b0;
        m_state    = segre_pkg::NOT_FLUSHING;
        repeat (10) @(posedge clk_i);
        #2;
        rsn_i = 1'b1;

        // Idle outputs out of reset
        err_mark = errors;
        repeat (3) idle_cycle();
        close_test("reset", err_mark);

        // Fill, forward each, then a miss that flushes
        err_mark = errors;
        for (int i = 0; i < 4; i++) begin
            store_word(pool_addr(i), 32'hA000_0000 + i);
        end
        for (int i = 0; i < 4; i++) begin
            load_word(pool_addr(i));
        end
        load_word(pool_addr(7));
        wait_flush_done();
        close_test("fill_forward", err_mark);

        // Overwrite on a full buffer, occupancy stays at four
        err_mark = errors;
        for (int i = 0; i < 4; i++) begin
            store_word(pool_addr(i), 32'hB000_0000 + i);
        end
        store_word(pool_addr(1), 32'hC0DE_0001);
        load_word(pool_addr(1));
        drains = 0;
        repeat (6) begin
            alu_cycle();
            drains += seen_drain;
        end
        checks++;
        assert (drains == 4) else begin
            errors++;
            $display("ERR %0t drain count expected 4 got %0d", $time, drains);
        end
        close_test("coalescing", err_mark);

        // Oldest first, strobe quiet once empty
        err_mark = errors;
        for (int i = 0; i < 3; i++) begin
            store_word(pool_addr(i + 3), 32'hD000_0000 + i);
        end
        repeat (5) alu_cycle();
        close_test("drain_order", err_mark);

        // Full store flush with ignored stores, then load miss flushes
        err_mark = errors;
        for (int i = 0; i < 4; i++) begin
            store_word(pool_addr(i), 32'hE000_0000 + i);
        end
        store_word(pool_addr(4), 32'hDEAD_0004);
        for (int i = 5; i < 8; i++) begin
            store_word(pool_addr(i), 32'hE100_0000 + i);
        end
        wait_flush_done();
        // Dropped and ignored stores must miss
        load_word(pool_addr(4));
        wait_flush_done();
        load_word(pool_addr(5));
        wait_flush_done();
        store_word(pool_addr(2), 32'hF000_0002);
        store_word(pool_addr(6), 32'hF000_0006);
        load_word(pool_addr(0));
        wait_flush_done();
        close_test("flush", err_mark);

        // Random mix, one instruction class per cycle at most
        err_mark = errors;
        for (int n = 0; n < 2000; n++) begin
            int          op;
            logic        hit;
            logic [31:0] a;
            logic [31:0] d;
            op  = $unsigned($random(seed)) % 4;
            hit = ($unsigned($random(seed)) % 8) != 0;
            a   = pool_addr($unsigned($random(seed)) % 8);
            d   = $random(seed);
            case (op)
                1: run_cycle(1'b1, 1'b0, 1'b0, hit, a, d);
                2: run_cycle(1'b0, 1'b1, 1'b0, hit, a, d);
                3: run_cycle(1'b0, 1'b0, 1'b1, hit, a, d);
                default: run_cycle(1'b0, 1'b0, 1'b0, hit, a, d);
            endcase
        end
        close_test("random_mix", err_mark);

        $display("Tests ok %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_ok, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_segre_store_buffer

//--- segre_store_buffer.f
segre_pkg.sv
segre_sb_entry_if.sv
segre_sb_entry.sv
segre_sb_ctrl.sv
segre_sb_read.sv
segre_store_buffer.sv
tb_segre_store_buffer.sv
